/* filelist.f */
src/snn_pkg.sv
src/packet_ctrl.sv
src/weight_mem.sv
src/neuron_unit.sv
src/snn_core_top.sv
dv/tb_snn_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_snn_core -o sim_snn

./obj_dir/sim_snn > sim.log 2>&1
cat sim.log

grep -q "Simulation PASSED" sim.log
echo "run_sim: pass"

/* dv/tb_snn_core.sv */
`timescale 1ns/1ps

module tb_snn_core import snn_pkg::*; ();

    localparam int N_INPUTS  = 4;
    localparam int THRESHOLD = 1000;
    localparam int TIMEOUT   = 50;
    localparam longint WMAX  = 64'sh7FFF_FFFF;
    localparam longint WMIN  = -64'sh8000_0000;

    logic        clk;
    logic        rst;
    logic        load_data;
    logic [7:0]  data;
    logic        busy;
    logic        done;
    logic        spike;
    word_t       potential;
    neuron_cfg_t cfg;

    integer      seed;
    int          errors;
    int          test_errors;
    int          tests;
    word_t       wts [N_INPUTS];    // what memory holds at 0..N_INPUTS-1
    word_t       model_pot;         // expected potential, carried between runs
    neuron_cfg_t cur_cfg;

    snn_core_top #(.N_INPUTS(N_INPUTS), .THRESHOLD(THRESHOLD)) i_dut (.*);

    always #5 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_cfg(input string name, input neuron_cfg_t exp, input neuron_cfg_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    function automatic neuron_cfg_t make_cfg(logic [2:0] d, logic [2:0] b, logic [1:0] m,
                                             logic a);
        make_cfg = '{d, b, m, a};
    endfunction

    task automatic send_byte(input logic [7:0] b);
        load_data = 1'b1;
        data      = b;
        @(negedge clk);
        load_data = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic send_cfg(input cmd_e cmd, input neuron_cfg_t c);
        send_byte(cmd);
        send_byte({c.adder_model, c.init_mode_adder, c.decay_mode});
        send_byte({7'd0, c.init_mode_acc});
        cur_cfg = c;
    endtask

    task automatic send_control(input neuron_cfg_t c);
        send_cfg(CMD_SET_CONTROL, c);
    endtask

    task automatic send_word(input word_t v);
        for (int i = 0; i < 4; i++)
            send_byte(v[8*i +: 8]);     // least significant first
    endtask

    task automatic send_addr_weight(input neuron_cfg_t c, input addr_t a, input word_t v);
        send_cfg(CMD_ADDR_WEIGHT, c);
        send_byte(a[7:0]);
        send_byte({6'd0, a[9:8]});
        send_word(v);
    endtask

    // wts[0] goes to address 0, the rest by auto-increment
    task automatic send_weights(input neuron_cfg_t c);
        send_addr_weight(c, '0, wts[0]);
        for (int i = 1; i < N_INPUTS; i++) begin
            send_cfg(CMD_WEIGHT, c);
            send_word(wts[i]);
        end
    endtask

    task automatic send_end();
        load_data = 1'b1;
        data      = CMD_END_PACKET;
        @(negedge clk);
        load_data = 1'b0;   // load is high from here on for one cycle
    endtask

    // lat counts edges after the one that samples load
    task automatic wait_done(output int lat, output word_t pre);
        lat = -1;
        pre = potential;
        for (int n = 0; n < TIMEOUT && lat < 0; n++) begin
            @(negedge clk);
            if (done) begin
                lat = n;
            end else begin
                if (!busy) begin
                    $display("busy was low before done, %0d cycles after load", n);
                    test_errors++;
                end
                pre = potential;
            end
        end
        if (lat < 0) begin
            $display("no done pulse within %0d cycles after load", TIMEOUT);
            test_errors++;
        end
    endtask

    function automatic word_t expect_accum(word_t p, neuron_cfg_t c);
        longint s;
        word_t  w;
        if (c.init_mode_acc)
            p = '0;
        else if (c.decay_mode != 3'd0)
            p = p - (p >>> c.decay_mode);
        p = p + int'(c.init_mode_adder) * 256;
        for (int i = 0; i < N_INPUTS; i++) begin
            w = wts[i];
            case (c.adder_model)
                ADD_SAT: begin
                    s = longint'(p) + longint'(w);
                    p = (s > WMAX) ? word_t'(WMAX) : (s < WMIN) ? word_t'(WMIN) : word_t'(s);
                end
                ADD_ABS: p = p + ((w < 0) ? -w : w);
                ADD_SUB: p = p - w;
                default: p = p + w;
            endcase
        end
        return p;
    endfunction

    task automatic run_and_check(input string name);
        int    lat;
        word_t pre;
        word_t want;
        logic  fire;
        want = expect_accum(model_pot, cur_cfg);
        fire = (want >= THRESHOLD);
        send_end();
        wait_done(lat, pre);
        if (lat >= 0) begin
            check_word({name, " sum"}, want, pre);
            check_bit({name, " spike"}, fire, spike);
            model_pot = fire ? word_t'(0) : want;
            check_word({name, " potential"}, model_pot, potential);
            check_word({name, " latency"}, word_t'(N_INPUTS + 3), word_t'(lat));
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        check_bit("reset done", 1'b0, done);
        check_bit("reset spike", 1'b0, spike);
        check_bit("reset busy", 1'b0, busy);
        check_word("reset potential", '0, potential);
        check_cfg("reset cfg", '0, cfg);
        finish_test("reset_state");
    endtask

    task automatic test_control_decode();
        logic [7:0]  b0;
        logic [7:0]  b1;
        neuron_cfg_t want;
        for (int k = 0; k < 3; k++) begin
            b0 = 8'($random(seed));
            b1 = 8'($random(seed));
            want.decay_mode      = b0[2:0];
            want.init_mode_adder = b0[5:3];
            want.adder_model     = b0[7:6];
            want.init_mode_acc   = b1[0];
            send_byte(CMD_SET_CONTROL);
            send_byte(b0);
            send_byte(b1);
            check_cfg("control_decode", want, cfg);
            cur_cfg = want;
        end
        finish_test("control_decode");
    endtask

    task automatic test_write_wrap_sub();
        foreach (wts[i])
            wts[i] = $random(seed);
        send_weights(make_cfg(3'd0, 3'd0, ADD_WRAP, 1'b1));
        run_and_check("wrap");
        send_control(make_cfg(3'd0, 3'd0, ADD_SUB, 1'b1));
        run_and_check("sub");
        finish_test("write_wrap_sub");
    endtask

    task automatic test_sat_abs();
        int r;
        foreach (wts[i]) begin
            r = $random(seed);
            wts[i] = 32'h7FFF_FFF0 - {24'd0, r[7:0]};
        end
        send_weights(make_cfg(3'd0, 3'd0, ADD_SAT, 1'b1));
        run_and_check("sat");
        foreach (wts[i]) begin
            r = $random(seed);
            wts[i] = 32'hFFFF_FF80 | {25'd0, r[6:0]};  // -128 .. -1
        end
        send_weights(make_cfg(3'd0, 3'd0, ADD_ABS, 1'b1));
        run_and_check("abs");
        finish_test("sat_abs");
    endtask

    task automatic test_leak_bias_spike();
        foreach (wts[i])
            wts[i] = 200;
        send_weights(make_cfg(3'd0, 3'd0, ADD_WRAP, 1'b1));
        run_and_check("leak start");
        foreach (wts[i])
            wts[i] = 0;
        send_weights(make_cfg(3'd0, 3'd0, ADD_WRAP, 1'b1));
        for (int d = 1; d <= 3; d++) begin
            send_control(make_cfg(3'(d), 3'd1, ADD_WRAP, 1'b0));
            run_and_check($sformatf("leak %0d", d));
        end
        send_control(make_cfg(3'd1, 3'd4, ADD_WRAP, 1'b0));  // big bias crosses threshold
        run_and_check("leak fire");
        check_bit("leak fire spike", 1'b1, spike);
        finish_test("leak_bias_spike");
    endtask

    initial begin
        seed        = 32'h4942;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        model_pot   = '0;
        cur_cfg     = '0;
        clk         = 1'b0;
        rst         = 1'b1;
        load_data   = 1'b0;
        data        = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_control_decode();
        test_write_wrap_sub();
        test_sat_abs();
        test_leak_bias_spike();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src/snn_core_top.sv */
`timescale 1ns/1ps

module snn_core_top import snn_pkg::*; #(
    parameter int N_INPUTS  = 4,
    parameter int THRESHOLD = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        load_data,
    input  logic [7:0]  data,
    output logic        busy,
    output logic        done,
    output logic        spike,
    output word_t       potential,
    output neuron_cfg_t cfg
);

    logic       load;
    weight_wr_t weight_wr;
    logic       rd_en;
    addr_t      rd_addr;
    word_t      rd_data;

    packet_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .load_data (load_data),
        .data      (data),
        .load      (load),
        .cfg       (cfg),
        .weight_wr (weight_wr)
    );

    weight_mem i_mem (
        .clk       (clk),
        .weight_wr (weight_wr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    neuron_unit #(
        .N_INPUTS  (N_INPUTS),
        .THRESHOLD (THRESHOLD)
    ) i_neuron (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .cfg       (cfg),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .busy      (busy),
        .done      (done),
        .spike     (spike),
        .potential (potential)
    );

endmodule

/* src/neuron_unit.sv */
`timescale 1ns/1ps

module neuron_unit import snn_pkg::*; #(
    parameter int N_INPUTS  = 4,
    parameter int THRESHOLD = 1000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  neuron_cfg_t cfg,
    input  word_t       rd_data,
    output logic        rd_en,
    output addr_t       rd_addr,
    output logic        busy,
    output logic        done,
    output logic        spike,
    output word_t       potential
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LEAK,
        S_READ,
        S_DRAIN,
        S_CMP
    } phase_e;

    phase_e phase;
    addr_t  idx;
    logic   rd_valid;   // rd_data holds a fresh weight
    word_t  leaked;
    word_t  start;

    function automatic word_t combine(word_t p, word_t w, logic [1:0] model);
        word_t sum;
        word_t mag;
        sum = p + w;
        mag = w[31] ? -w : w;
        case (model)
            ADD_SAT: begin
                // overflow only when both signs agree and the result flips
                if (p[31] == w[31] && sum[31] != p[31]) begin
                    combine = p[31] ? word_t'(32'h8000_0000) : word_t'(32'h7FFF_FFFF);
                end else begin
                    combine = sum;
                end
            end
            ADD_ABS: combine = p + mag;
            ADD_SUB: combine = p - w;
            default: combine = sum;     // ADD_WRAP
        endcase
    endfunction

    always_comb begin
        if (cfg.init_mode_acc) begin
            leaked = '0;
        end else if (cfg.decay_mode == 3'd0) begin
            leaked = potential;         // no leak
        end else begin
            leaked = potential - (potential >>> cfg.decay_mode);
        end
        start = leaked + (word_t'(cfg.init_mode_adder) <<< BIAS_SHIFT);
    end

    assign rd_en   = (phase == S_READ);
    assign rd_addr = idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= S_IDLE;
            idx       <= '0;
            rd_valid  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            spike     <= 1'b0;
            potential <= '0;
        end else begin
            done     <= 1'b0;
            spike    <= 1'b0;
            rd_valid <= rd_en;
            if (rd_valid) begin
                potential <= combine(potential, rd_data, cfg.adder_model);
            end
            case (phase)
                S_IDLE: begin
                    if (load) begin
                        busy  <= 1'b1;
                        phase <= S_LEAK;
                    end
                end
                S_LEAK: begin
                    potential <= start;
                    idx       <= '0;
                    phase     <= S_READ;
                end
                S_READ: begin
                    idx <= idx + addr_t'(1);
                    if (idx == addr_t'(N_INPUTS - 1)) begin
                        phase <= S_DRAIN;
                    end
                end
                S_DRAIN: phase <= S_CMP;   // last weight lands here
                S_CMP: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    phase <= S_IDLE;
                    if (potential >= word_t'(THRESHOLD)) begin
                        spike     <= 1'b1;
                        potential <= '0;
                    end
                end
                default: phase <= S_IDLE;
            endcase
        end
    end

    a_done_from_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> $past(busy)
    );

    // the decoder has no back-pressure, a load here is dropped
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (rst) load |-> !busy
    ) else $error("load pulse while neuron busy");

endmodule

/* src/weight_mem.sv */
`timescale 1ns/1ps

module weight_mem import snn_pkg::*; (
    input  logic       clk,
    input  weight_wr_t weight_wr,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    output word_t      rd_data
);

    localparam int DEPTH = 2 ** $bits(addr_t);

    word_t mem [DEPTH];

    // write port, fed by the decoder
    always_ff @(posedge clk) begin
        if (weight_wr.valid) begin
            mem[weight_wr.addr] <= weight_wr.value;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* src/packet_ctrl.sv */
`timescale 1ns/1ps

module packet_ctrl import snn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        load_data,
    input  logic [7:0]  data,
    output logic        load,
    output neuron_cfg_t cfg,
    output weight_wr_t  weight_wr
);

    ctrl_state_e state;
    buf_mode_e   buf_mode;
    cmd_e        cmd;
    logic [7:0]  buffer [4];
    logic [1:0]  cnt;

    // byte assembly, written in every state except select
    always_ff @(posedge clk) begin
        if (load_data && state != ST_SELECT) begin
            buffer[cnt] <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_SELECT;
            buf_mode  <= BUF_IDLE;
            cmd       <= CMD_SET_CONTROL;
            cnt       <= '0;
            load      <= 1'b0;
            cfg       <= '0;
            weight_wr <= '0;
        end else begin
            load            <= 1'b0;
            weight_wr.valid <= 1'b0;
            if (load_data) begin
                case (state)
                    ST_SELECT: begin
                        if (data == CMD_END_PACKET) begin
                            load <= 1'b1;
                        end else begin
                            cmd   <= cmd_e'(data);  // unknown codes only touch cfg
                            cnt   <= '0;
                            state <= ST_LOAD;
                        end
                    end
                    ST_LOAD: begin
                        cnt <= cnt + 2'd1;
                        if (cnt == 2'd1) begin
                            cfg.decay_mode      <= buffer[0][2:0];
                            cfg.init_mode_adder <= buffer[0][5:3];
                            cfg.adder_model     <= buffer[0][7:6];
                            cfg.init_mode_acc   <= data[0];
                            cnt                 <= '0;
                            if (cmd == CMD_ADDR_WEIGHT) begin
                                state    <= ST_BUFFER;
                                buf_mode <= BUF_ADDRESS;
                            end else if (cmd == CMD_WEIGHT) begin
                                state          <= ST_BUFFER;
                                buf_mode       <= BUF_VALUE;
                                weight_wr.addr <= weight_wr.addr + addr_t'(1); // wraps at 1023
                            end else begin
                                state <= ST_SELECT;
                            end
                        end
                    end
                    ST_BUFFER: begin
                        cnt <= cnt + 2'd1;
                        if (buf_mode == BUF_ADDRESS) begin
                            if (cnt == 2'd1) begin
                                weight_wr.addr <= {data[1:0], buffer[0]};
                                buf_mode       <= BUF_VALUE;
                                cnt            <= '0;
                            end
                        end else if (buf_mode == BUF_VALUE) begin
                            if (cnt == 2'd3) begin
                                // little endian, last byte straight from the port
                                weight_wr.value <= {data, buffer[2], buffer[1], buffer[0]};
                                weight_wr.valid <= 1'b1;
                                buf_mode        <= BUF_IDLE;
                                state           <= ST_SELECT;
                                cnt             <= '0;
                            end
                        end else begin
                            state <= ST_SELECT;
                        end
                    end
                    default: state <= ST_SELECT;
                endcase
            end
        end
    end

    // a write is always followed by at least one more byte before the next one
    a_single_write: assert property (
        @(posedge clk) disable iff (rst) weight_wr.valid |=> !weight_wr.valid
    );

endmodule

/* src/snn_pkg.sv */
package snn_pkg;

    typedef logic [9:0] addr_t;
    typedef logic signed [31:0] word_t;

    // command byte values
    typedef enum logic [7:0] {
        CMD_SET_CONTROL = 8'h01,
        CMD_ADDR_WEIGHT = 8'h02,
        CMD_WEIGHT      = 8'h03,
        CMD_END_PACKET  = 8'hFF
    } cmd_e;

    typedef enum logic [1:0] {
        ST_SELECT,
        ST_LOAD,
        ST_BUFFER
    } ctrl_state_e;

    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_ADDRESS,
        BUF_VALUE
    } buf_mode_e;

    // adder model codes
    localparam logic [1:0] ADD_WRAP = 2'd0;
    localparam logic [1:0] ADD_SAT  = 2'd1;
    localparam logic [1:0] ADD_ABS  = 2'd2;
    localparam logic [1:0] ADD_SUB  = 2'd3;

    // bias step is init_mode_adder * 256
    localparam int BIAS_SHIFT = 8;

    typedef struct packed {
        logic [2:0] decay_mode;
        logic [2:0] init_mode_adder;
        logic [1:0] adder_model;
        logic       init_mode_acc;
    } neuron_cfg_t;

    typedef struct packed {
        logic  valid;   // one-cycle write strobe
        addr_t addr;
        word_t value;
    } weight_wr_t;

endpackage
